//--- logic/soc_pkg.sv
package soc_pkg;

    // bus widths
    localparam int ADR_W = 32;
    localparam int DAT_W = 8;

    // internal reset hold after the external reset is released
    localparam int RESET_HOLD = 16;

    // block RAM at the bottom of the map, 1024 bytes
    localparam int BRAM_ADR_BITS = 10;

    // timer page, matched on the upper 24 bits
    localparam logic [ADR_W-1:0] TIMER_BASE = 32'hFFFF_FD00;

    // prng page, matched on the upper 24 bits
    localparam logic [ADR_W-1:0] PRNG_BASE = 32'hFFFF_FE00;

    // led register, matched on the upper 28 bits
    localparam logic [ADR_W-1:0] LEDS_BASE = 32'hFFFF_FFF0;

    // returned for reads outside the map
    localparam logic [DAT_W-1:0] UNMAPPED_DATA = 8'hFF;

    // galois feedback mask, x^16 + x^14 + x^13 + x^11 + 1
    localparam logic [15:0] LFSR_TAPS = 16'hB400;

endpackage

//--- logic/reset_stretch.sv
`timescale 1ns/1ps

module reset_stretch (
    input  logic clk,
    input  logic rst_i,
    output logic rst_o
);

    logic [$clog2(soc_pkg::RESET_HOLD)-1:0] hold_cnt;
    logic                                   rst_q;

    // block RAM contents are not reliable right after configuration,
    // so the rest of the system waits a few cycles longer
    always_ff @(posedge clk) begin
        if (rst_i) begin
            hold_cnt <= '0;
            rst_q    <= 1'b1;
        end else if (rst_q) begin
            hold_cnt <= hold_cnt + 1'b1;
            if (hold_cnt == soc_pkg::RESET_HOLD - 1) begin
                rst_q <= 1'b0;
            end
        end
    end

    assign rst_o = rst_q;

endmodule

//--- logic/bus_decode.sv
`timescale 1ns/1ps

module bus_decode (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [soc_pkg::ADR_W-1:0]  wb_adr_i,
    input  logic                       wb_stb_i,
    output logic                       bram_stb_o,
    output logic                       leds_stb_o,
    output logic                       timer_stb_o,
    output logic                       prng_stb_o,
    input  logic [soc_pkg::DAT_W-1:0]  bram_dat_i,
    input  logic [soc_pkg::DAT_W-1:0]  leds_dat_i,
    input  logic [soc_pkg::DAT_W-1:0]  timer_dat_i,
    input  logic [soc_pkg::DAT_W-1:0]  prng_dat_i,
    input  logic                       bram_ack_i,
    input  logic                       leds_ack_i,
    input  logic                       timer_ack_i,
    input  logic                       prng_ack_i,
    output logic [soc_pkg::DAT_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o
);

    logic bram_sel;
    logic leds_sel;
    logic timer_sel;
    logic prng_sel;
    logic none_sel;
    logic none_ack_q;

    // 0x00000000 - 0x000003FF
    assign bram_sel = (wb_adr_i[soc_pkg::ADR_W-1:soc_pkg::BRAM_ADR_BITS] == '0);

    // 0xFFFFFDxx
    assign timer_sel = (wb_adr_i[soc_pkg::ADR_W-1:8] == soc_pkg::TIMER_BASE[soc_pkg::ADR_W-1:8]);

    // 0xFFFFFExx
    assign prng_sel = (wb_adr_i[soc_pkg::ADR_W-1:8] == soc_pkg::PRNG_BASE[soc_pkg::ADR_W-1:8]);

    // 0xFFFFFFFx
    assign leds_sel = (wb_adr_i[soc_pkg::ADR_W-1:4] == soc_pkg::LEDS_BASE[soc_pkg::ADR_W-1:4]);

    assign none_sel = ~(bram_sel | timer_sel | prng_sel | leds_sel);

    assign bram_stb_o  = wb_stb_i & bram_sel;
    assign leds_stb_o  = wb_stb_i & leds_sel;
    assign timer_stb_o = wb_stb_i & timer_sel;
    assign prng_stb_o  = wb_stb_i & prng_sel;

    // answer for holes in the map, otherwise the master would hang
    always_ff @(posedge clk) begin
        if (rst_i) begin
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= wb_stb_i & none_sel & ~none_ack_q;
        end
    end

    // selects are one-hot, an and-or tree is enough
    assign wb_dat_o = ({soc_pkg::DAT_W{bram_sel}}  & bram_dat_i)
                    | ({soc_pkg::DAT_W{leds_sel}}  & leds_dat_i)
                    | ({soc_pkg::DAT_W{timer_sel}} & timer_dat_i)
                    | ({soc_pkg::DAT_W{prng_sel}}  & prng_dat_i)
                    | ({soc_pkg::DAT_W{none_sel}}  & soc_pkg::UNMAPPED_DATA);

    assign wb_ack_o = (bram_sel  & bram_ack_i)
                    | (leds_sel  & leds_ack_i)
                    | (timer_sel & timer_ack_i)
                    | (prng_sel  & prng_ack_i)
                    | (none_sel  & none_ack_q);

endmodule

//--- logic/bram_wb8.sv
`timescale 1ns/1ps

module bram_wb8 #(
    parameter int ADR_BITS = soc_pkg::BRAM_ADR_BITS
) (
    input  logic                       clk,
    input  logic [ADR_BITS-1:0]        wb_adr_i,
    input  logic [soc_pkg::DAT_W-1:0]  wb_dat_i,
    input  logic                       wb_we_i,
    input  logic                       wb_stb_i,
    output logic [soc_pkg::DAT_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o
);

    logic [soc_pkg::DAT_W-1:0] mem [0:(1 << ADR_BITS)-1];
    logic [soc_pkg::DAT_W-1:0] dat_q;
    logic                      ack_q;
    logic                      access;

    // first edge of a strobe only
    assign access = wb_stb_i & ~ack_q;

    always_ff @(posedge clk) begin
        if (access) begin
            if (wb_we_i) begin
                mem[wb_adr_i] <= wb_dat_i;
            end
            dat_q <= mem[wb_adr_i];
        end
    end

    always_ff @(posedge clk) begin
        ack_q <= access;
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;

endmodule

//--- logic/leds_wb8.sv
`timescale 1ns/1ps

module leds_wb8 (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [soc_pkg::DAT_W-1:0]  wb_dat_i,
    input  logic                       wb_we_i,
    input  logic                       wb_stb_i,
    output logic [soc_pkg::DAT_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o,
    output logic [soc_pkg::DAT_W-1:0]  leds_o
);

    logic [soc_pkg::DAT_W-1:0] leds_q;
    logic                      ack_q;
    logic                      access;

    assign access = wb_stb_i & ~ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && wb_we_i) begin
                leds_q <= wb_dat_i;
            end
        end
    end

    // register is stable, so it can be read back directly
    assign wb_dat_o = leds_q;
    assign wb_ack_o = ack_q;
    assign leds_o   = leds_q;

endmodule

//--- logic/timer_wb8.sv
`timescale 1ns/1ps

module timer_wb8 (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [1:0]                 wb_adr_i,
    input  logic [soc_pkg::DAT_W-1:0]  wb_dat_i,
    input  logic                       wb_we_i,
    input  logic                       wb_stb_i,
    output logic [soc_pkg::DAT_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o,
    output logic                       irq_o
);

    logic [15:0]               reload_q;
    logic [15:0]               count_q;
    logic                      enable_q;
    logic                      pending_q;
    logic                      ack_q;
    logic [soc_pkg::DAT_W-1:0] dat_q;
    logic                      access;
    logic                      commit;
    logic                      ctrl_wr;
    logic                      expire;

    assign access = wb_stb_i & ~ack_q;

    // writes take effect on the edge that completes the access
    assign commit  = wb_stb_i & wb_we_i & ack_q;
    assign ctrl_wr = commit & (wb_adr_i == 2'd2);
    assign expire  = enable_q & (count_q == 16'd0);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (wb_adr_i)
                2'd0:    dat_q <= reload_q[7:0];
                2'd1:    dat_q <= reload_q[15:8];
                2'd2:    dat_q <= {7'b0, enable_q};
                default: dat_q <= {7'b0, pending_q};
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (commit && wb_adr_i == 2'd0) begin
            reload_q[7:0] <= wb_dat_i;
        end
        if (commit && wb_adr_i == 2'd1) begin
            reload_q[15:8] <= wb_dat_i;
        end
    end

    // period is reload + 1 cycles
    always_ff @(posedge clk) begin
        if (ctrl_wr && wb_dat_i[0]) begin
            count_q <= reload_q;
        end else if (expire) begin
            count_q <= reload_q;
        end else if (enable_q) begin
            count_q <= count_q - 16'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                enable_q <= wb_dat_i[0];
                if (wb_dat_i[1]) begin
                    pending_q <= 1'b0;
                end
            end
            // a new expiry beats a clear in the same cycle
            if (expire) begin
                pending_q <= 1'b1;
            end
        end
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;
    assign irq_o    = pending_q;

endmodule

//--- logic/prng_wb8.sv
`timescale 1ns/1ps

module prng_wb8 (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [1:0]                 wb_adr_i,
    input  logic [soc_pkg::DAT_W-1:0]  wb_dat_i,
    input  logic                       wb_we_i,
    input  logic                       wb_stb_i,
    output logic [soc_pkg::DAT_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o
);

    logic [15:0]               state_q;
    logic [15:0]               state_step;
    logic [15:0]               seed;
    logic [soc_pkg::DAT_W-1:0] seed_lo_q;
    logic [soc_pkg::DAT_W-1:0] dat_q;
    logic                      ack_q;
    logic                      access;

    assign access = wb_stb_i & ~ack_q;
    assign seed   = {wb_dat_i, seed_lo_q};

    // one galois step, feedback from the bit shifted out
    assign state_step = {1'b0, state_q[15:1]} ^ (state_q[0] ? soc_pkg::LFSR_TAPS : 16'h0000);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= 16'h0001;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= access;
            if (access && wb_we_i && wb_adr_i == 2'd1) begin
                // all-zero state would lock up
                state_q <= (seed == 16'h0000) ? 16'h0001 : seed;
            end else if (access && !wb_we_i && wb_adr_i == 2'd0) begin
                state_q <= state_step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access && wb_we_i && wb_adr_i == 2'd0) begin
            seed_lo_q <= wb_dat_i;
        end
        if (access && !wb_we_i) begin
            case (wb_adr_i)
                2'd0:    dat_q <= state_q[7:0];
                2'd1:    dat_q <= state_q[15:8];
                default: dat_q <= '0;
            endcase
        end
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;

endmodule

//--- logic/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top (
    input  logic                       clk,
    input  logic                       rst_i,
    input  logic [soc_pkg::ADR_W-1:0]  wb_adr_i,
    input  logic [soc_pkg::DAT_W-1:0]  wb_dat_i,
    input  logic                       wb_we_i,
    input  logic                       wb_stb_i,
    output logic [soc_pkg::DAT_W-1:0]  wb_dat_o,
    output logic                       wb_ack_o,
    output logic [soc_pkg::DAT_W-1:0]  leds_o,
    output logic                       irq_o
);

    logic                      sys_rst;

    logic                      bram_stb;
    logic                      leds_stb;
    logic                      timer_stb;
    logic                      prng_stb;

    logic [soc_pkg::DAT_W-1:0] bram_dat;
    logic [soc_pkg::DAT_W-1:0] leds_dat;
    logic [soc_pkg::DAT_W-1:0] timer_dat;
    logic [soc_pkg::DAT_W-1:0] prng_dat;

    logic                      bram_ack;
    logic                      leds_ack;
    logic                      timer_ack;
    logic                      prng_ack;

    reset_stretch u_reset (
        .clk   (clk),
        .rst_i (rst_i),
        .rst_o (sys_rst)
    );

    bus_decode u_decode (
        .clk         (clk),
        .rst_i       (sys_rst),
        .wb_adr_i    (wb_adr_i),
        .wb_stb_i    (wb_stb_i),
        .bram_stb_o  (bram_stb),
        .leds_stb_o  (leds_stb),
        .timer_stb_o (timer_stb),
        .prng_stb_o  (prng_stb),
        .bram_dat_i  (bram_dat),
        .leds_dat_i  (leds_dat),
        .timer_dat_i (timer_dat),
        .prng_dat_i  (prng_dat),
        .bram_ack_i  (bram_ack),
        .leds_ack_i  (leds_ack),
        .timer_ack_i (timer_ack),
        .prng_ack_i  (prng_ack),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o)
    );

    bram_wb8 u_bram (
        .clk      (clk),
        .wb_adr_i (wb_adr_i[soc_pkg::BRAM_ADR_BITS-1:0]),
        .wb_dat_i (wb_dat_i),
        .wb_we_i  (wb_we_i),
        .wb_stb_i (bram_stb),
        .wb_dat_o (bram_dat),
        .wb_ack_o (bram_ack)
    );

    leds_wb8 u_leds (
        .clk      (clk),
        .rst_i    (sys_rst),
        .wb_dat_i (wb_dat_i),
        .wb_we_i  (wb_we_i),
        .wb_stb_i (leds_stb),
        .wb_dat_o (leds_dat),
        .wb_ack_o (leds_ack),
        .leds_o   (leds_o)
    );

    timer_wb8 u_timer (
        .clk      (clk),
        .rst_i    (sys_rst),
        .wb_adr_i (wb_adr_i[1:0]),
        .wb_dat_i (wb_dat_i),
        .wb_we_i  (wb_we_i),
        .wb_stb_i (timer_stb),
        .wb_dat_o (timer_dat),
        .wb_ack_o (timer_ack),
        .irq_o    (irq_o)
    );

    prng_wb8 u_prng (
        .clk      (clk),
        .rst_i    (sys_rst),
        .wb_adr_i (wb_adr_i[1:0]),
        .wb_dat_i (wb_dat_i),
        .wb_we_i  (wb_we_i),
        .wb_stb_i (prng_stb),
        .wb_dat_o (prng_dat),
        .wb_ack_o (prng_ack)
    );

endmodule

//--- tb/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb;

    localparam int    ACK_LIMIT  = 8;
    localparam int    RAND_TESTS = 16;
    localparam string STIM_FILE  = "tb/bus_stimulus.txt";

    logic        clk;
    logic        rst_i;
    logic [31:0] wb_adr;
    logic [7:0]  wb_dat_w;
    logic        wb_we;
    logic        wb_stb;
    logic [7:0]  wb_dat_r;
    logic        wb_ack;
    logic [7:0]  leds;
    logic        irq;

    int          cycle_cnt;
    int          last_ack;
    int          watchdog_cycles;
    int          n_pass;
    int          n_fail;
    logic [15:0] prng_model;
    logic [7:0]  seed_lo;

    string       op_q [$];
    logic [31:0] adr_q [$];
    logic [7:0]  wdat_q [$];
    logic [7:0]  exp_q [$];
    int          cyc_q [$];
    string       name_q [$];

    soc_bus_top uut (
        .clk      (clk),
        .rst_i    (rst_i),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_we_i  (wb_we),
        .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack),
        .leds_o   (leds),
        .irq_o    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // rising edge count for the irq timing checks
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the run did not complete", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    // shift right and fold in the taps when a 1 drops out
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ soc_pkg::LFSR_TAPS;
        end
        return n;
    endfunction

    task automatic bus_access(input logic [31:0] adr, input logic [7:0] wdat, input logic we,
                              output logic [7:0] rdat, output bit acked);
        int waited;
        waited = 0;
        acked  = 1'b0;
        rdat   = '0;
        @(posedge clk);
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        wb_we    <= we;
        wb_stb   <= 1'b1;
        while (!acked && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
            if (wb_ack) begin
                acked    = 1'b1;
                rdat     = wb_dat_r;
                last_ack = cycle_cnt + 1;
            end
        end
        // the edge that sees ack ends the access
        @(posedge clk);
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic check_byte(input string name, input logic [7:0] want,
                              input logic [7:0] got, inout bit ok);
        assert (got === want) else begin
            $display("ERR %s expected %02h actual %02h", name, want, got);
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input string name, input bit ok);
        if (ok) begin
            n_pass++;
            $display("test %s ok", name);
        end else begin
            n_fail++;
            $display("test %s failed", name);
        end
    endtask

    task automatic load_stimulus(output bit ok);
        int          fd;
        int          got;
        string       op;
        string       rest;
        logic [31:0] adr;
        logic [7:0]  wdat;
        logic [7:0]  want;
        int          cyc;
        string       name;
        fd = $fopen(STIM_FILE, "r");
        ok = (fd != 0);
        while (ok && !$feof(fd)) begin
            got = $fscanf(fd, "%s", op);
            if (got == 1 && op[0] == "#") begin
                got = $fgets(rest, fd);
            end else if (got == 1) begin
                got = $fscanf(fd, "%h %h %h %d %s", adr, wdat, want, cyc, name);
                ok = (got == 5) && (op == "W" || op == "R" || op == "Q" || op == "C");
                op_q.push_back(op);
                adr_q.push_back(adr);
                wdat_q.push_back(wdat);
                exp_q.push_back(want);
                cyc_q.push_back(cyc);
                name_q.push_back(name);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic run_line(input int i);
        logic [31:0] adr;
        logic [7:0]  got;
        bit          acked;
        bit          ok;
        bit          is_prng;
        bit          is_leds;
        ok      = 1'b1;
        adr     = adr_q[i];
        is_prng = (adr[31:8] == soc_pkg::PRNG_BASE[31:8]);
        is_leds = (adr[31:4] == soc_pkg::LEDS_BASE[31:4]);
        if (op_q[i] == "W" || op_q[i] == "R") begin
            bus_access(adr, wdat_q[i], op_q[i] == "W", got, acked);
            assert (acked) else begin
                $display("%s: no acknowledge from bus", name_q[i]);
                ok = 1'b0;
            end
            if (op_q[i] == "W" && is_prng && adr[1:0] == 2'd0) begin
                seed_lo = wdat_q[i];
            end else if (op_q[i] == "W" && is_prng && adr[1:0] == 2'd1) begin
                prng_model = {wdat_q[i], seed_lo};
                if (prng_model == 16'h0000) begin
                    prng_model = 16'h0001;
                end
            end else if (op_q[i] == "R" && acked) begin
                check_byte(name_q[i], exp_q[i], got, ok);
                if (is_prng && adr[1:0] == 2'd0) begin
                    check_byte(name_q[i], prng_model[7:0], got, ok);
                    prng_model = lfsr_next(prng_model);
                end
                if (is_leds) begin
                    @(negedge clk);
                    check_byte(name_q[i], exp_q[i], leds, ok);
                end
            end
        end else if (op_q[i] == "Q") begin
            // counted from the edge that acknowledged the last access
            do @(negedge clk); while (cycle_cnt < last_ack + cyc_q[i]);
            assert (cycle_cnt == last_ack + cyc_q[i]) else begin
                $display("%s: sample point already passed", name_q[i]);
                ok = 1'b0;
            end
            check_byte(name_q[i], exp_q[i], {7'b0, irq}, ok);
        end else begin
            repeat (cyc_q[i]) @(posedge clk);
            @(negedge clk);
            check_byte(name_q[i], 8'h00, {7'b0, irq}, ok);
        end
        finish_test(name_q[i], ok);
    endtask

    task automatic run_random();
        logic [7:0] model [RAND_TESTS];
        bit         wr_ok [RAND_TESTS];
        logic [7:0] got;
        bit         acked;
        bit         ok;
        int         k;
        for (k = 0; k < RAND_TESTS; k++) begin
            model[k] = 8'($urandom());
            bus_access(32'h0000_0100 + k, model[k], 1'b1, got, wr_ok[k]);
        end
        for (k = 0; k < RAND_TESTS; k++) begin
            bus_access(32'h0000_0100 + k, 8'h00, 1'b0, got, acked);
            ok = 1'b1;
            assert (wr_ok[k] && acked) else begin
                $display("rand_ram_%0d: no acknowledge from bus", k);
                ok = 1'b0;
            end
            check_byte($sformatf("rand_ram_%0d", k), model[k], got, ok);
            finish_test($sformatf("rand_ram_%0d", k), ok);
        end
    endtask

    initial begin
        bit      loaded;
        int      i;
        int      seed;
        rst_i      = 1'b1;
        wb_adr     = '0;
        wb_dat_w   = '0;
        wb_we      = 1'b0;
        wb_stb     = 1'b0;
        prng_model = 16'h0001;
        seed_lo    = 8'h00;
        seed       = 32'h9ba035c3;
        void'($urandom(seed));
        load_stimulus(loaded);
        if (loaded) begin
            watchdog_cycles = op_q.size() * 40 + RAND_TESTS * 10 + 10 + soc_pkg::RESET_HOLD + 2;
            repeat (10) @(posedge clk);
            rst_i <= 1'b0;
            repeat (soc_pkg::RESET_HOLD + 2) @(posedge clk);
            for (i = 0; i < op_q.size(); i++) begin
                run_line(i);
            end
            run_random();
        end else begin
            $display("stimulus file %s missing or malformed", STIM_FILE);
            n_fail++;
        end
        $display("tests: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- tb/bus_stimulus.txt
# op address write_data expected cycles name
# W write, R read and compare, Q irq_o after cycles from last ack, C irq_o low after cycles
R fffffff0 00 00 0 leds_reset
C 00000000 00 00 0 irq_reset
W 00000000 a5 00 0 ram_wr_low
W 00000200 3c 00 0 ram_wr_mid
W 000003ff c7 00 0 ram_wr_top
R 00000000 00 a5 0 ram_rd_low
R 00000200 00 3c 0 ram_rd_mid
R 000003ff 00 c7 0 ram_rd_top
W fffffff0 96 00 0 leds_wr
R fffffff0 00 96 0 leds_rd
W fffffe00 e1 00 0 prng_seed_lo
W fffffe01 ac 00 0 prng_seed_hi
R fffffe00 00 e1 0 prng_step_0
R fffffe00 00 70 0 prng_step_1
R fffffe00 00 38 0 prng_step_2
R fffffe00 00 9c 0 prng_step_3
R fffffe00 00 4e 0 prng_step_4
R fffffe00 00 27 0 prng_step_5
R fffffe01 00 b3 0 prng_high
R fffffe00 00 13 0 prng_step_6
W fffffe00 00 00 0 prng_zero_lo
W fffffe01 00 00 0 prng_zero_hi
R fffffe00 00 01 0 prng_zero_step_0
R fffffe01 00 b4 0 prng_zero_high
W fffffd00 14 00 0 timer_reload_lo
W fffffd01 00 00 0 timer_reload_hi
W fffffd02 01 00 0 timer_enable
Q 00000000 00 00 20 timer_irq_early
Q 00000000 00 01 21 timer_irq_due
R fffffd03 00 01 0 timer_status
W fffffd02 02 00 0 timer_clear
C 00000000 00 00 0 timer_irq_cleared
C 00000000 00 00 30 timer_irq_stays_low
R fffffa10 00 ff 0 unmapped_rd_hi
R 00100000 00 ff 0 unmapped_rd_lo
W fffffa10 5a 00 0 unmapped_wr_hi
W 00100000 5a 00 0 unmapped_wr_lo
R fffffff0 00 96 0 unmapped_leds_kept
R 00000000 00 a5 0 unmapped_ram_kept

//--- sources.f
logic/soc_pkg.sv
logic/reset_stretch.sv
logic/bus_decode.sv
logic/bram_wb8.sv
logic/leds_wb8.sv
logic/timer_wb8.sv
logic/prng_wb8.sv
logic/soc_bus_top.sv
tb/soc_bus_tb.sv
